/* Bender.yml */
package:
  name: grom
  description: "Small 8-bit accumulator processor with its testbench"

sources:
  - files:
      - src/cpu_pkg.sv
      - src/isa_pkg.sv
      - src/cpu_ifs.sv
      - src/instr_fetch.sv
      - src/reg_file.sv
      - src/alu.sv
      - src/cpu_sequencer.sv
      - src/bus_master.sv
      - src/grom_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_grom.sv

/* all.f */
+incdir+test
src/cpu_pkg.sv
src/isa_pkg.sv
src/cpu_ifs.sv
src/instr_fetch.sv
src/reg_file.sv
src/alu.sv
src/cpu_sequencer.sv
src/bus_master.sv
src/grom_top.sv
test/tb_grom.sv

/* src/alu.sv */
`timescale 1ns/100ps

module alu (
	input  logic     clk,
	input  logic     reset,
	alu_if.responder alu
);
	import cpu_pkg::*;

	alu_op_t    op_q;
	data_t      a_q;
	data_t      b_q;
	logic       busy;   // Operands latched, result due
	logic [8:0] sum;    // Bit 8 is carry or borrow
	flags_t     flags_next;

	always_ff @(posedge clk)
	begin
		if (alu.start)
		begin
			op_q <= alu.op;
			a_q  <= alu.a;
			b_q  <= alu.b;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			busy <= 1'b0;
		else
			busy <= alu.start;
	end

	always_comb
	begin
		sum = '0;   // Logic ops leave carry clear
		case (op_q)
			alu_add: sum = {1'b0, a_q} + {1'b0, b_q};
			alu_sub: sum = {1'b0, a_q} - {1'b0, b_q};
			alu_adc: sum = {1'b0, a_q} + {1'b0, b_q} + alu.flags[flag_c];
			alu_sbc: sum = {1'b0, a_q} - {1'b0, b_q} - alu.flags[flag_c];
			alu_and: sum[7:0] = a_q & b_q;
			alu_or:  sum[7:0] = a_q | b_q;
			alu_not: sum[7:0] = ~a_q;
			alu_xor: sum[7:0] = a_q ^ b_q;
			default: sum = '0;
		endcase
		flags_next         = '0;
		flags_next[flag_c] = sum[8];
		flags_next[flag_z] = (sum[7:0] == '0);
		flags_next[flag_s] = sum[7];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			alu.flags <= '0;
		else if (busy)
			alu.flags <= flags_next;   // Held until the next operation
	end

	always_ff @(posedge clk)
	begin
		if (busy)
			alu.result <= sum[7:0];
	end

	a_known_op: assert property (@(posedge clk) disable iff (reset)
		alu.start |-> (!$isunknown(alu.op) && alu.op inside {[alu_add:alu_xor]}))
		else $error("ALU started with unknown op %0h", alu.op);

endmodule

/* src/bus_master.sv */
`timescale 1ns/100ps

module bus_master (
	input  logic           clk,
	input  logic           reset,
	bus_req_if.responder   bus,
	output cpu_pkg::addr_t addr,
	output cpu_pkg::data_t data_out,
	output logic           we,
	output logic           ioreq
);

	// Strobes follow req, so they drop on their own
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			we    <= 1'b0;
			ioreq <= 1'b0;
		end
		else
		begin
			we    <= bus.req && bus.write;
			ioreq <= bus.req && bus.io;
		end
	end

	always_ff @(posedge clk)
	begin
		if (bus.req)
		begin
			addr <= bus.req_addr;   // Held through the read wait
			if (bus.write)
				data_out <= bus.wdata;
		end
	end

	// Only OUT drives ioreq
	a_io_write: assert property (@(posedge clk) disable iff (reset)
		ioreq |-> we)
		else $error("ioreq without we");

endmodule

/* src/cpu_ifs.sv */
`timescale 1ns/100ps

interface fetch_if;
	import cpu_pkg::*;

	logic  load_ir;
	logic  load_operand;
	logic  jump;
	addr_t jump_target;
	addr_t pc;
	data_t ir;
	data_t operand;

	modport controller (
		output load_ir, load_operand, jump, jump_target,
		input  pc, ir, operand
	);

	modport responder (
		input  load_ir, load_operand, jump, jump_target,
		output pc, ir, operand
	);
endinterface

interface alu_if;
	import cpu_pkg::*;

	logic    start;
	alu_op_t op;
	data_t   a;
	data_t   b;
	data_t   result;
	flags_t  flags;

	modport controller (output start, op, a, b, input result, flags);
	modport responder (input start, op, a, b, output result, flags);
endinterface

interface bus_req_if;
	import cpu_pkg::*;

	logic  req;
	logic  write;
	logic  io;
	addr_t req_addr;
	data_t wdata;

	modport controller (output req, write, io, req_addr, wdata);
	modport responder (input req, write, io, req_addr, wdata);
endinterface

/* src/cpu_pkg.sv */
package cpu_pkg;

	typedef logic [7:0]  data_t;
	typedef logic [11:0] addr_t;
	typedef logic [1:0]  reg_idx_t;   // R0 to R3

	// Low two bits follow instruction bits 3:2
	typedef enum logic [3:0] {
		alu_add = 4'h0,
		alu_sub = 4'h1,
		alu_adc = 4'h2,
		alu_sbc = 4'h3,
		alu_and = 4'h4,
		alu_or  = 4'h5,
		alu_not = 4'h6,
		alu_xor = 4'h7
	} alu_op_t;

	typedef logic [2:0] flags_t;

	// Bit positions in flags_t
	parameter int flag_c = 0;
	parameter int flag_z = 1;
	parameter int flag_s = 2;

endpackage

/* src/cpu_sequencer.sv */
`timescale 1ns/100ps

module cpu_sequencer (
	input  logic              clk,
	input  logic              reset,
	fetch_if.controller       fetch,
	alu_if.controller         alu,
	bus_req_if.controller     bus,
	output cpu_pkg::reg_idx_t rd_a_idx,
	output cpu_pkg::reg_idx_t rd_b_idx,
	input  cpu_pkg::data_t    rd_a,
	input  cpu_pkg::data_t    rd_b,
	output logic              wr_en,
	output cpu_pkg::reg_idx_t wr_idx,
	output cpu_pkg::data_t    wr_data,
	input  cpu_pkg::data_t    data_in,
	output logic              hlt
);
	import cpu_pkg::*;
	import isa_pkg::*;

	typedef enum logic [3:0] {
		fetch_req,
		fetch_wait,
		fetch_cap,
		execute,
		operand_req,
		operand_wait,
		operand_cap,
		execute_long,
		alu_wait,
		alu_write,
		load_wait,
		load_cap,
		halted
	} state_t;

	state_t        state;
	state_t        state_next;
	opcode_group_t group;
	page_t         jump_page;
	reg_idx_t      dest_idx;
	reg_idx_t      dest_next;
	logic          take;
	logic          next_fetch;   // Request the next opcode

	assign group     = opcode_group_t'(fetch.ir[6:4]);
	assign jump_page = fetch.ir[3:0];
	assign rd_a_idx  = (group == grp_store) ? fetch.ir[3:2] : reg_idx_t'(0);   // Else R0
	assign rd_b_idx  = fetch.ir[1:0];
	assign hlt       = (state == halted);

	always_comb
	begin
		case (cond_t'(fetch.ir[2:0]))
			cond_always: take = 1'b1;
			cond_c:      take = alu.flags[flag_c];
			cond_nc:     take = !alu.flags[flag_c];
			cond_m:      take = alu.flags[flag_s];
			cond_p:      take = !alu.flags[flag_s];
			cond_z:      take = alu.flags[flag_z];
			cond_nz:     take = !alu.flags[flag_z];
			cond_never:  take = 1'b0;
		endcase
	end

	always_comb
	begin
		state_next         = state;
		next_fetch         = 1'b0;
		dest_next          = dest_idx;
		fetch.load_ir      = 1'b0;
		fetch.load_operand = 1'b0;
		fetch.jump         = 1'b0;
		fetch.jump_target  = addr_t'(fetch.operand);   // Zero page
		alu.start          = 1'b0;
		alu.op             = alu_add;
		alu.a              = rd_a;
		alu.b              = rd_b;
		bus.req            = 1'b0;
		bus.write          = 1'b0;
		bus.io             = 1'b0;
		bus.req_addr       = fetch.pc;
		bus.wdata          = rd_b;
		wr_en              = 1'b0;
		wr_idx             = dest_idx;
		wr_data            = rd_b;

		case (state)
			fetch_req:
				next_fetch = 1'b1;
			fetch_wait:
				state_next = fetch_cap;
			fetch_cap:
			begin
				fetch.load_ir = 1'b1;
				state_next    = data_in[long_bit] ? operand_req : execute;
			end
			execute:
			begin
				if (fetch.ir == halt_opcode)
					state_next = halted;
				else
				begin
					case (group)
						grp_mov_jcc:
						begin
							wr_en      = 1'b1;
							wr_idx     = fetch.ir[3:2];
							next_fetch = 1'b1;
						end
						grp_arith_jump, grp_logic:
						begin
							alu.start  = 1'b1;
							alu.op     = alu_op_t'({1'b0, group == grp_logic, fetch.ir[3:2]});
							dest_next  = '0;   // Result to R0
							state_next = alu_wait;
						end
						grp_unary:
						begin
							alu.start = 1'b1;
							dest_next = fetch.ir[1:0];
							case (unary_op_t'(fetch.ir[3:2]))
								un_inc:
								begin
									alu.a      = rd_b;
									alu.b      = data_t'(1);
									state_next = alu_wait;
								end
								un_dec:
								begin
									alu.op     = alu_sub;
									alu.a      = rd_b;
									alu.b      = data_t'(1);
									state_next = alu_wait;
								end
								un_cmp:
								begin
									alu.op     = alu_sub;
									next_fetch = 1'b1;   // Flags only
								end
								un_tst:
								begin
									alu.op     = alu_and;
									next_fetch = 1'b1;
								end
							endcase
						end
						grp_load_out:
						begin
							bus.req      = 1'b1;
							bus.req_addr = addr_t'(rd_b);
							dest_next    = fetch.ir[3:2];
							state_next   = load_wait;
						end
						grp_store:
						begin
							bus.req      = 1'b1;
							bus.write    = 1'b1;
							bus.req_addr = addr_t'(rd_a);
							state_next   = fetch_req;
						end
						default:
							next_fetch = 1'b1;
					endcase
				end
			end
			operand_req:
			begin
				bus.req    = 1'b1;
				state_next = operand_wait;
			end
			operand_wait:
				state_next = operand_cap;
			operand_cap:
			begin
				fetch.load_operand = 1'b1;
				state_next         = execute_long;
			end
			execute_long:
			begin
				case (group)
					grp_mov_jcc:
					begin
						fetch.jump = !fetch.ir[3] && take;   // Relative forms dropped
						next_fetch = 1'b1;
					end
					grp_arith_jump:
					begin
						fetch.jump        = 1'b1;
						fetch.jump_target = {jump_page, fetch.operand};
						next_fetch        = 1'b1;
					end
					grp_load_out:
					begin
						bus.req      = 1'b1;
						bus.write    = 1'b1;
						bus.io       = 1'b1;
						bus.req_addr = addr_t'(fetch.operand);
						state_next   = fetch_req;
					end
					grp_sys_mem:
					begin
						case (mem_op_t'(fetch.ir[3:2]))
							mem_imm:
							begin
								wr_en      = 1'b1;
								wr_idx     = fetch.ir[1:0];
								wr_data    = fetch.operand;
								next_fetch = 1'b1;
							end
							mem_load:
							begin
								bus.req      = 1'b1;
								bus.req_addr = addr_t'(fetch.operand);
								dest_next    = fetch.ir[1:0];
								state_next   = load_wait;
							end
							mem_store:
							begin
								bus.req      = 1'b1;
								bus.write    = 1'b1;
								bus.req_addr = addr_t'(fetch.operand);
								state_next   = fetch_req;
							end
							mem_none:
								next_fetch = 1'b1;
						endcase
					end
					default:
						next_fetch = 1'b1;   // Operand byte already consumed
				endcase
			end
			alu_wait:
				state_next = alu_write;
			alu_write:
			begin
				wr_en      = 1'b1;
				wr_data    = alu.result;
				next_fetch = 1'b1;
			end
			load_wait:
				state_next = load_cap;
			load_cap:
			begin
				wr_en      = 1'b1;
				wr_data    = data_in;
				next_fetch = 1'b1;
			end
			halted:
				state_next = halted;
			default:
				state_next = fetch_req;
		endcase

		// Next opcode read overlaps the last cycle of this one
		if (next_fetch)
		begin
			bus.req      = 1'b1;
			bus.write    = 1'b0;
			bus.req_addr = fetch.jump ? fetch.jump_target : fetch.pc;
			state_next   = fetch_wait;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= fetch_req;
		else
			state <= state_next;
	end

	always_ff @(posedge clk)
		dest_idx <= dest_next;

	a_halt_quiet: assert property (@(posedge clk) disable iff (reset)
		(state == halted) |-> !bus.req)
		else $error("Bus request after HALT");

endmodule

/* src/grom_top.sv */
`timescale 1ns/100ps

module grom_top #(
	parameter cpu_pkg::addr_t reset_pc = '0
) (
	input  logic           clk,
	input  logic           reset,
	output cpu_pkg::addr_t addr,
	input  cpu_pkg::data_t data_in,
	output cpu_pkg::data_t data_out,
	output logic           we,
	output logic           ioreq,
	output logic           hlt
);
	import cpu_pkg::*;

	reg_idx_t rd_a_idx;
	reg_idx_t rd_b_idx;
	data_t    rd_a;
	data_t    rd_b;
	logic     wr_en;
	reg_idx_t wr_idx;
	data_t    wr_data;

	fetch_if   fetch_bus ();
	alu_if     alu_bus ();
	bus_req_if bus_req ();

	instr_fetch #(
		.reset_pc(reset_pc)
	) i_fetch (
		.clk     (clk),
		.reset   (reset),
		.data_in (data_in),
		.fetch   (fetch_bus)
	);

	cpu_sequencer i_seq (
		.clk      (clk),
		.reset    (reset),
		.fetch    (fetch_bus),
		.alu      (alu_bus),
		.bus      (bus_req),
		.rd_a_idx (rd_a_idx),
		.rd_b_idx (rd_b_idx),
		.rd_a     (rd_a),
		.rd_b     (rd_b),
		.wr_en    (wr_en),
		.wr_idx   (wr_idx),
		.wr_data  (wr_data),
		.data_in  (data_in),
		.hlt      (hlt)
	);

	reg_file i_regs (
		.clk      (clk),
		.reset    (reset),
		.rd_a_idx (rd_a_idx),
		.rd_b_idx (rd_b_idx),
		.rd_a     (rd_a),
		.rd_b     (rd_b),
		.wr_en    (wr_en),
		.wr_idx   (wr_idx),
		.wr_data  (wr_data)
	);

	alu i_alu (
		.clk   (clk),
		.reset (reset),
		.alu   (alu_bus)
	);

	bus_master i_bus (
		.clk      (clk),
		.reset    (reset),
		.bus      (bus_req),
		.addr     (addr),
		.data_out (data_out),
		.we       (we),
		.ioreq    (ioreq)
	);

endmodule

/* src/instr_fetch.sv */
`timescale 1ns/100ps

module instr_fetch #(
	parameter cpu_pkg::addr_t reset_pc = '0
) (
	input  logic           clk,
	input  logic           reset,
	input  cpu_pkg::data_t data_in,
	fetch_if.responder     fetch
);

	always_ff @(posedge clk)
	begin
		if (reset)
			fetch.pc <= reset_pc;
		else if (fetch.jump)
			fetch.pc <= fetch.jump_target;
		else if (fetch.load_ir || fetch.load_operand)
			fetch.pc <= fetch.pc + 1'b1;   // Past the captured byte
	end

	always_ff @(posedge clk)
	begin
		if (fetch.load_ir)
			fetch.ir <= data_in;
		if (fetch.load_operand)
			fetch.operand <= data_in;
	end

	// Opcode and operand bytes come from separate reads
	a_one_capture: assert property (@(posedge clk) disable iff (reset)
		!(fetch.load_ir && fetch.load_operand))
		else $error("load_ir and load_operand high together");

	// A jump never lands on the cycle that captures a byte
	a_jump_alone: assert property (@(posedge clk) disable iff (reset)
		fetch.jump |-> !(fetch.load_ir || fetch.load_operand))
		else $error("jump collides with a byte capture");

endmodule

/* src/isa_pkg.sv */
package isa_pkg;

	// Opcode bits 6:4, short form first, long form second
	typedef enum logic [2:0] {
		grp_mov_jcc    = 3'd0,   // MOV Rd,Rs / Jcc zero page
		grp_arith_jump = 3'd1,   // ADD..SBC / JUMP absolute
		grp_logic      = 3'd2,   // AND..XOR / CALL, dropped
		grp_unary      = 3'd3,   // INC DEC CMP TST / MOV SP, dropped
		grp_stack_in   = 3'd4,   // Shifts and stack / IN, all dropped
		grp_load_out   = 3'd5,   // LOAD Rd,[Rs] / OUT
		grp_store      = 3'd6,   // STORE [Rd],Rs / segment loads, dropped
		grp_sys_mem    = 3'd7    // HALT / MOV imm, LOAD, STORE direct
	} opcode_group_t;

	typedef enum logic [1:0] {
		un_inc = 2'd0,
		un_dec = 2'd1,
		un_cmp = 2'd2,
		un_tst = 2'd3
	} unary_op_t;

	// Long group 7, bits 3:2
	typedef enum logic [1:0] {
		mem_imm   = 2'd0,
		mem_load  = 2'd1,
		mem_store = 2'd2,
		mem_none  = 2'd3
	} mem_op_t;

	typedef enum logic [2:0] {
		cond_always = 3'd0,
		cond_c      = 3'd1,
		cond_nc     = 3'd2,
		cond_m      = 3'd3,
		cond_p      = 3'd4,
		cond_z      = 3'd5,
		cond_nz     = 3'd6,
		cond_never  = 3'd7
	} cond_t;

	typedef logic [3:0] page_t;   // Upper nibble of an absolute target

	parameter int long_bit = 7;
	parameter cpu_pkg::data_t halt_opcode = 8'h7F;

endpackage

/* src/reg_file.sv */
`timescale 1ns/100ps

module reg_file (
	input  logic              clk,
	input  logic              reset,
	input  cpu_pkg::reg_idx_t rd_a_idx,
	input  cpu_pkg::reg_idx_t rd_b_idx,
	output cpu_pkg::data_t    rd_a,
	output cpu_pkg::data_t    rd_b,
	input  logic              wr_en,
	input  cpu_pkg::reg_idx_t wr_idx,
	input  cpu_pkg::data_t    wr_data
);
	import cpu_pkg::*;

	localparam int num_regs = 2 ** $bits(reg_idx_t);

	data_t regs [num_regs];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < num_regs; i++)
				regs[i] <= '0;
		end
		else if (wr_en)
			regs[wr_idx] <= wr_data;
	end

	assign rd_a = regs[rd_a_idx];
	assign rd_b = regs[rd_b_idx];

endmodule

/* test/tb_program.svh */
`ifndef tb_program_svh
`define tb_program_svh

logic [7:0] lfsr_state = 8'd59;
data_t      ref_mem [4096];   // Memory as the program should leave it
data_t      m_reg [4];
logic       m_c;
logic       m_z;
logic       m_s;
int         prog_len;
int         prog_bytes;
addr_t      exp_st_addr [$];
data_t      exp_st_data [$];
string      exp_st_name [$];
addr_t      exp_out_port [$];
data_t      exp_out_data [$];
string      exp_out_name [$];

// x^8 + x^6 + x^5 + x^4 + 1
function automatic logic lfsr_bit();
	logic fb;
	fb = lfsr_state[7] ^ lfsr_state[5] ^ lfsr_state[4] ^ lfsr_state[3];
	lfsr_state = {lfsr_state[6:0], fb};
	return fb;
endfunction

function automatic data_t rand_byte();
	data_t v;
	v = '0;
	for (int i = 0; i < 8; i++)
		v = {v[6:0], lfsr_bit()};
	return v;
endfunction

function automatic data_t fill_byte(int a);
	return data_t'(a) ^ data_t'(a >> 4) ^ 8'hA5;
endfunction

// Result and flags by the instruction set rules
function automatic data_t model_alu(logic [2:0] op, data_t a, data_t b);
	int    wide;
	data_t res;
	case (op)
		3'd0: wide = int'(a) + int'(b);
		3'd1: wide = int'(a) - int'(b);
		3'd2: wide = int'(a) + int'(b) + int'(m_c);
		3'd3: wide = int'(a) - int'(b) - int'(m_c);
		3'd4: wide = int'(a & b);
		3'd5: wide = int'(a | b);
		3'd6: wide = int'(~a);
		default: wide = int'(a ^ b);
	endcase
	res = data_t'(wide);
	m_c = !op[2] && (wide < 0 || wide > 255);   // Carry out or borrow
	m_z = (res == 8'h00);
	m_s = res[7];
	return res;
endfunction

task automatic emit(data_t b);
	mem[prog_len]     = b;
	ref_mem[prog_len] = b;
	prog_len++;
	prog_bytes++;
endtask

task automatic expect_store(addr_t a, data_t d, string name);
	exp_st_addr.push_back(a);
	exp_st_data.push_back(d);
	exp_st_name.push_back(name);
	ref_mem[a] = d;
endtask

task automatic mov_imm(reg_idx_t d, data_t v);
	emit({6'b111100, d});
	emit(v);
	m_reg[d] = v;
endtask

task automatic mov_reg(reg_idx_t d, reg_idx_t s);
	emit({4'b0000, d, s});
	m_reg[d] = m_reg[s];
endtask

task automatic alu_op(logic [2:0] op, reg_idx_t s);
	emit({2'b00, op[2], !op[2], op[1:0], s});
	m_reg[0] = model_alu(op, m_reg[0], m_reg[s]);
endtask

task automatic unary(logic [1:0] u, reg_idx_t r);
	emit({4'b0011, u, r});
	case (u)
		2'd0: m_reg[r] = model_alu(3'd0, m_reg[r], 8'd1);
		2'd1: m_reg[r] = model_alu(3'd1, m_reg[r], 8'd1);
		2'd2: void'(model_alu(3'd1, m_reg[0], m_reg[r]));   // CMP sets flags only
		default: void'(model_alu(3'd4, m_reg[0], m_reg[r]));
	endcase
endtask

task automatic store_dir(data_t a, reg_idx_t s, string name);
	emit({6'b111110, s});
	emit(a);
	expect_store(addr_t'(a), m_reg[s], name);
endtask

task automatic store_ind(reg_idx_t d, reg_idx_t s, string name);
	emit({4'b0110, d, s});
	expect_store(addr_t'(m_reg[d]), m_reg[s], name);
endtask

task automatic load_dir(reg_idx_t d, data_t a);
	emit({6'b111101, d});
	emit(a);
	m_reg[d] = ref_mem[addr_t'(a)];
endtask

task automatic load_ind(reg_idx_t d, reg_idx_t s);
	emit({4'b0101, d, s});
	m_reg[d] = ref_mem[addr_t'(m_reg[s])];
endtask

task automatic out_port(data_t p, reg_idx_t s, logic runs, string name);
	emit({6'b110100, s});
	emit(p);
	if (runs)
	begin
		exp_out_port.push_back(addr_t'(p));
		exp_out_data.push_back(m_reg[s]);
		exp_out_name.push_back(name);
	end
endtask

// CMP of known values, then a conditional jump over one OUT
task automatic jump_test(logic [2:0] cond, data_t x, data_t y);
	logic  taken;
	data_t land;
	string name;
	name = $sformatf("jcc%0d_%02h_%02h", cond, x, y);
	mov_imm(2'd0, x);
	mov_imm(2'd1, y);
	unary(2'd2, 2'd1);
	case (cond)
		3'd0: taken = 1'b1;
		3'd1: taken = m_c;
		3'd2: taken = !m_c;
		3'd3: taken = m_s;
		3'd4: taken = !m_s;
		3'd5: taken = m_z;
		default: taken = !m_z;
	endcase
	land = data_t'(prog_len + 4);
	emit({5'b10000, cond});
	emit(land);
	out_port({5'b01000, cond}, 2'd2, !taken, name);
	out_port({5'b01000, cond}, 2'd3, 1'b1, name);
endtask

task automatic build_program();
	data_t    pair_x [2];
	data_t    pair_y [2];
	reg_idx_t r;
	for (int a = 0; a < 4096; a++)
	begin
		mem[a]     = fill_byte(a);
		ref_mem[a] = fill_byte(a);
	end
	for (int i = 0; i < 4; i++)
		m_reg[i] = '0;
	m_c        = 1'b0;
	m_z        = 1'b0;
	m_s        = 1'b0;
	prog_len   = int'(reset_pc);
	prog_bytes = 0;
	pair_x     = '{8'h05, 8'h09};
	pair_y     = '{8'h09, 8'h09};

	// Jump tests stay in the zero page
	mov_imm(2'd2, 8'h55);
	mov_imm(2'd3, 8'hAA);
	for (int c = 0; c < 7; c++)
	begin
		// Each flag differs between the two pairs
		for (int p = 0; p < 2; p++)
			jump_test(3'(c), pair_x[p], pair_y[p]);
	end
	emit({4'b1001, 4'h7});   // JUMP 0x7A0
	emit(8'hA0);
	out_port(8'hEE, 2'd0, 1'b0, "jump_abs");   // Skipped
	prog_len = 'h7A0;

	mov_imm(2'd0, rand_byte());
	store_dir(8'hE0, 2'd0, "mov_imm");
	mov_reg(2'd1, 2'd0);
	mov_imm(2'd0, rand_byte());
	store_dir(8'hE1, 2'd1, "mov_reg");
	mov_imm(2'd2, 8'hE2);
	store_ind(2'd2, 2'd0, "store_ind");

	for (int round = 0; round < 2; round++)
	begin
		for (int k = 0; k < 8; k++)
		begin
			r = reg_idx_t'(1 + k % 3);
			mov_imm(2'd0, rand_byte());
			mov_imm(r, rand_byte());
			alu_op(3'(k), r);
			store_dir(data_t'(8'hE8 + k), 2'd0, $sformatf("alu_op%0d_round%0d", k, round));
		end
	end

	// INC, DEC, CMP, TST, then both registers stored
	for (int u = 0; u < 4; u++)
	begin
		r = reg_idx_t'(1 + u % 3);
		mov_imm(2'd0, rand_byte());
		mov_imm(r, rand_byte());
		unary(2'(u), r);
		store_dir(data_t'(8'hF0 + u), r, $sformatf("unary%0d_reg", u));
		store_dir(data_t'(8'hF4 + u), 2'd0, $sformatf("unary%0d_r0", u));
	end

	load_dir(2'd2, 8'hE8);
	store_dir(8'hD0, 2'd2, "load_dir");
	load_dir(2'd3, 8'hC5);
	store_dir(8'hD1, 2'd3, "load_dir_fill");
	mov_imm(2'd1, 8'hE1);
	load_ind(2'd0, 2'd1);
	store_dir(8'hD2, 2'd0, "load_ind");
	emit(halt_opcode);
	emit({6'b111110, 2'd0});   // Store that must never run
	emit(8'hD3);
endtask

`endif

/* test/tb_grom.sv */
`timescale 1ns/100ps

module tb_grom;
	import cpu_pkg::*;
	import isa_pkg::*;

	localparam addr_t reset_pc = 12'h010;

	logic  clk;
	logic  reset;
	addr_t addr;
	data_t data_in;
	data_t data_out;
	logic  we;
	logic  ioreq;
	logic  hlt;
	data_t mem [4096];
	int    errors = 0;
	int    checks = 0;
	int    cycles = 0;
	int    limit = 0;
	logic  built = 1'b0;

	`include "tb_program.svh"

	grom_top #(
		.reset_pc(reset_pc)
	) i_dut (
		.clk      (clk),
		.reset    (reset),
		.addr     (addr),
		.data_in  (data_in),
		.data_out (data_out),
		.we       (we),
		.ioreq    (ioreq),
		.hlt      (hlt)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#10 clk = ~clk;
	end

	task automatic check_store(addr_t a, data_t d);
		addr_t ea;
		data_t ed;
		string name;
		checks++;
		assert (exp_st_addr.size() != 0)
		else
		begin
			errors++;
			$display("unexpected store of %02h to %03h", d, a);
		end
		if (exp_st_addr.size() != 0)
		begin
			ea   = exp_st_addr.pop_front();
			ed   = exp_st_data.pop_front();
			name = exp_st_name.pop_front();
			assert (a == ea && d == ed)
			else
			begin
				errors++;
				$display("mismatch %s: expected %02h at %03h, actual %02h at %03h",
					name, ed, ea, d, a);
			end
		end
	endtask

	task automatic check_out(addr_t p, data_t d);
		addr_t ep;
		data_t ed;
		string name;
		checks++;
		assert (exp_out_port.size() != 0)
		else
		begin
			errors++;
			$display("unexpected OUT of %02h to port %03h", d, p);
		end
		if (exp_out_port.size() != 0)
		begin
			ep   = exp_out_port.pop_front();
			ed   = exp_out_data.pop_front();
			name = exp_out_name.pop_front();
			assert (p == ep && d == ed)
			else
			begin
				errors++;
				$display("mismatch %s: expected %02h on port %03h, actual %02h on port %03h",
					name, ed, ep, d, p);
			end
		end
	endtask

	task automatic report_and_finish();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	endtask

	// Memory sees the bus mid-cycle and answers reads there too
	always @(negedge clk)
	begin
		if (!reset && we && !ioreq)
		begin
			check_store(addr, data_out);
			mem[addr] = data_out;
		end
		if (!reset && we && ioreq)
			check_out(addr, data_out);
		data_in = mem[addr];
	end

	a_we_pulse: assert property (@(posedge clk) disable iff (reset) we |=> !we)
	else
	begin
		errors++;
		$display("we stayed high for more than one cycle");
	end

	a_io_pulse: assert property (@(posedge clk) disable iff (reset) ioreq |=> !ioreq)
	else
	begin
		errors++;
		$display("ioreq stayed high for more than one cycle");
	end

	a_io_with_we: assert property (@(posedge clk) disable iff (reset) ioreq |-> we)
	else
	begin
		errors++;
		$display("ioreq rose without we");
	end

	a_halt_no_write: assert property (@(posedge clk) disable iff (reset) hlt |-> !we)
	else
	begin
		errors++;
		$display("bus write issued after HALT");
	end

	a_halt_held: assert property (@(posedge clk) disable iff (reset) hlt |=> hlt)
	else
	begin
		errors++;
		$display("hlt fell before reset");
	end

	initial
	begin
		wait (built);
		while (cycles < limit)
		begin
			@(posedge clk);
			cycles++;
		end
		errors++;
		$display("timeout, hlt not raised within %0d cycles", limit);
		report_and_finish();
	end

	initial
	begin
		reset   = 1'b1;
		data_in = '0;
		build_program();
		limit = 12 * prog_bytes + 200;
		built = 1'b1;
		repeat (8)
			@(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		checks++;
		assert (!hlt && !we && !ioreq)
		else
		begin
			errors++;
			$display("hlt, we or ioreq high right after reset");
		end
		checks++;
		assert (addr == reset_pc)
		else
		begin
			errors++;
			$display("mismatch reset_addr: expected %03h, actual %03h", reset_pc, addr);
		end
		while (!hlt)
			@(negedge clk);
		repeat (20)   // Bus must stay quiet after HALT
			@(negedge clk);
		assert (exp_st_addr.size() == 0)
		else
		begin
			errors++;
			$display("%0d expected stores never happened", exp_st_addr.size());
		end
		assert (exp_out_port.size() == 0)
		else
		begin
			errors++;
			$display("%0d expected OUT writes never happened", exp_out_port.size());
		end
		report_and_finish();
	end

endmodule
